// ==== src/sd_frame_pkg.sv ====
`default_nettype none

// frames as they appear on the CMD line
package sd_frame_pkg;

	// start bit 47 first, must be 0
	typedef logic [47:0] cmd_frame_t;

	// long response is 136 bits; a 48-bit one sits right-aligned
	typedef logic [135:0] resp_frame_t;

	localparam int cmd_bits = 48;

	typedef logic [7:0] resp_len_t; // counts up to 136

endpackage

`default_nettype wire

// ==== src/sd_phy_ctrl_pkg.sv ====
`default_nettype none

// controller side: states and the control bundle to the shifters
package sd_phy_ctrl_pkg;

	typedef enum logic [2:0] {
		reset_st,
		idle_st,
		load_command,
		send_command,
		wait_response,
		send_response,
		wait_ack,
		send_ack
	} phy_state_t;

	typedef logic [6:0] timeout_cnt_t;

	typedef struct packed {
		logic reset_wrapper; // returns both shifters to idle
		logic enable_pts;
		logic enable_stp;
		logic load_send;
		logic pad_state;     // 1 while the host drives CMD
		logic pad_enable;
	} wrapper_ctrl_t;

endpackage

`default_nettype wire

// ==== src/cmd_serializer.sv ====
`default_nettype none

module cmd_serializer (
	input wire logic sd_clock,
	input wire logic reset,
	input wire sd_phy_ctrl_pkg::wrapper_ctrl_t wctrl,
	input wire sd_frame_pkg::cmd_frame_t command,
	output logic cmd_out,
	output logic transmission_complete
);
	import sd_frame_pkg::*;

	cmd_frame_t shift_reg;
	logic [5:0] bit_cnt;   // bits already put on cmd_out
	logic busy;
	logic done;            // frame sent and waiting for reset_wrapper
	logic start;

	assign start = wctrl.enable_pts && wctrl.load_send && !busy && !done;

	// last bit is on the line during this cycle
	assign transmission_complete = busy && (bit_cnt == 6'(cmd_bits));

	always_ff @(posedge sd_clock) begin
		if (reset || wctrl.reset_wrapper) begin
			busy <= 1'b0;
			done <= 1'b0;
			bit_cnt <= '0;
			cmd_out <= 1'b1; // line idles high
		end else if (start) begin
			cmd_out <= command[47];
			busy <= 1'b1;
			bit_cnt <= 6'd1;
		end else if (transmission_complete) begin
			cmd_out <= 1'b1;
			busy <= 1'b0;
			done <= 1'b1;
		end else if (busy) begin
			cmd_out <= shift_reg[47];
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// payload bits with the next one at the top
	always_ff @(posedge sd_clock) begin
		if (start)
			shift_reg <= command << 1;
		else if (busy)
			shift_reg <= shift_reg << 1;
	end

	// controller must not restart a send before this one is cleared
	assert property (@(posedge sd_clock) disable iff (reset)
		$rose(wctrl.load_send) |-> !busy && !done);

endmodule

`default_nettype wire

// ==== src/resp_deserializer.sv ====
`default_nettype none

module resp_deserializer #(
	parameter int resp_bits = 48
) (
	input wire logic sd_clock,
	input wire logic reset,
	input wire sd_phy_ctrl_pkg::wrapper_ctrl_t wctrl,
	input wire logic cmd_in,
	output sd_frame_pkg::resp_frame_t pad_response,
	output logic reception_complete
);
	import sd_frame_pkg::*;

	typedef enum logic [1:0] {
		rx_hunt,
		rx_shift,
		rx_done
	} rx_state_t;

	rx_state_t rx_state;
	resp_len_t bit_cnt; // start bit counts as the first
	logic last_bit;
	resp_frame_t shifted;

	assign last_bit = (bit_cnt == resp_len_t'(resp_bits - 1));
	assign shifted = {pad_response[$bits(resp_frame_t)-2:0], cmd_in};

	// frame clears on reset_wrapper, so a silent card reads back as zero
	always_ff @(posedge sd_clock) begin
		if (reset || wctrl.reset_wrapper) begin
			rx_state <= rx_hunt;
			bit_cnt <= '0;
			pad_response <= '0;
			reception_complete <= 1'b0;
		end else begin
			reception_complete <= 1'b0;
			case (rx_state)
				rx_hunt: begin
					if (wctrl.enable_stp && !cmd_in) begin
						pad_response <= shifted;
						bit_cnt <= 8'd1;
						rx_state <= rx_shift;
					end
				end
				rx_shift: begin
					if (wctrl.enable_stp) begin // hold if the controller gave up
						pad_response <= shifted;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							reception_complete <= 1'b1;
							rx_state <= rx_done;
						end
					end
				end
				default: begin
					rx_state <= rx_done; // keep frame until next reset_wrapper
				end
			endcase
		end
	end

	// controller keeps stp enabled until it has seen the pulse
	assert property (@(posedge sd_clock) disable iff (reset)
		reception_complete |-> wctrl.enable_stp);

endmodule

`default_nettype wire

// ==== src/cmd_phys_controller.sv ====
`default_nettype none

module cmd_phys_controller #(
	parameter int timeout_limit = 63
) (
	input wire logic sd_clock,
	input wire logic reset,
	input wire logic strobe_in,      // host has a command
	input wire logic ack_in,         // host took the response
	input wire logic idle_in,
	input wire logic no_response,
	input wire sd_frame_pkg::resp_frame_t pad_response,
	input wire logic transmission_complete,
	input wire logic reception_complete,
	output logic serial_ready,
	output logic ack_out,
	output logic strobe_out,         // response valid
	output sd_frame_pkg::resp_frame_t response,
	output sd_phy_ctrl_pkg::wrapper_ctrl_t wctrl,
	output logic command_timeout
);
	import sd_phy_ctrl_pkg::*;

	phy_state_t state;
	phy_state_t next_state;
	timeout_cnt_t timeout_count;
	logic stp_delay; // one cycle of turnaround before listening

	assign command_timeout = (timeout_count == timeout_cnt_t'(timeout_limit));

	always_ff @(posedge sd_clock) begin
		if (reset)
			state <= reset_st;
		else if (idle_in)
			state <= idle_st;
		else
			state <= next_state;
	end

	// both counters live only inside wait_response
	always_ff @(posedge sd_clock) begin
		if (reset || state != wait_response) begin
			timeout_count <= '0;
			stp_delay <= 1'b0;
		end else begin
			stp_delay <= 1'b1;
			if (!command_timeout)
				timeout_count <= timeout_count + 1'b1; // saturates at the limit
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			reset_st: next_state = idle_st;
			idle_st: begin
				if (strobe_in)
					next_state = load_command;
			end
			load_command: next_state = send_command;
			send_command: begin
				if (transmission_complete)
					next_state = wait_response;
			end
			wait_response: begin
				if (reception_complete || no_response)
					next_state = send_response;
			end
			send_response: next_state = wait_ack;
			wait_ack: begin
				if (ack_in)
					next_state = send_ack;
			end
			send_ack: next_state = idle_st;
			default: next_state = reset_st;
		endcase
	end

	// per-state output table
	always_comb begin
		serial_ready = 1'b0;
		ack_out = 1'b0;
		strobe_out = 1'b0;
		response = '0;
		wctrl = '0;
		case (state)
			reset_st: begin
				wctrl.reset_wrapper = 1'b1;
			end
			idle_st: begin
				wctrl.reset_wrapper = 1'b1;
				serial_ready = 1'b1;
			end
			load_command, send_command: begin
				wctrl.pad_state = 1'b1;
				wctrl.pad_enable = 1'b1;
				wctrl.enable_pts = 1'b1;
				wctrl.load_send = (state == send_command);
				serial_ready = 1'b1;
			end
			wait_response: begin
				wctrl.pad_enable = 1'b1;
				wctrl.enable_stp = stp_delay;
			end
			send_response, wait_ack, send_ack: begin
				strobe_out = 1'b1;
				response = pad_response;
				ack_out = (state == send_ack);
				serial_ready = 1'b1;
			end
			default: begin
				wctrl.reset_wrapper = 1'b1;
			end
		endcase
	end

	// a response is only offered straight out of the wait
	assert property (@(posedge sd_clock) disable iff (reset)
		$rose(strobe_out) |-> $past(state) == wait_response);

	// ack to the host is a single pulse
	assert property (@(posedge sd_clock) disable iff (reset)
		ack_out |=> !ack_out);

endmodule

`default_nettype wire

// ==== src/sd_cmd_phy.sv ====
`default_nettype none

module sd_cmd_phy #(
	parameter int resp_bits = 48,
	parameter int timeout_limit = 63
) (
	input wire logic sd_clock,
	input wire logic reset,
	// host side
	input wire logic strobe_in,
	input wire logic ack_in,
	input wire logic idle_in,
	input wire logic no_response,
	input wire sd_frame_pkg::cmd_frame_t command,
	output wire logic serial_ready,
	output wire logic strobe_out,
	output wire logic ack_out,
	output wire sd_frame_pkg::resp_frame_t response,
	output wire logic command_timeout,
	// pad side
	output wire logic cmd_out,
	output wire logic cmd_oe,
	input wire logic cmd_in,
	output wire logic pad_enable
);
	import sd_frame_pkg::*;
	import sd_phy_ctrl_pkg::*;

	wrapper_ctrl_t wctrl;
	resp_frame_t pad_response;
	logic transmission_complete;
	logic reception_complete;

	assign cmd_oe = wctrl.pad_state;
	assign pad_enable = wctrl.pad_enable;

	cmd_serializer u_pts (
		.sd_clock(sd_clock),
		.reset(reset),
		.wctrl(wctrl),
		.command(command),
		.cmd_out(cmd_out),
		.transmission_complete(transmission_complete)
	);

	resp_deserializer #(
		.resp_bits(resp_bits)
	) u_stp (
		.sd_clock(sd_clock),
		.reset(reset),
		.wctrl(wctrl),
		.cmd_in(cmd_in),
		.pad_response(pad_response),
		.reception_complete(reception_complete)
	);

	cmd_phys_controller #(
		.timeout_limit(timeout_limit)
	) u_ctrl (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.no_response(no_response),
		.pad_response(pad_response),
		.transmission_complete(transmission_complete),
		.reception_complete(reception_complete),
		.serial_ready(serial_ready),
		.ack_out(ack_out),
		.strobe_out(strobe_out),
		.response(response),
		.wctrl(wctrl),
		.command_timeout(command_timeout)
	);

endmodule

`default_nettype wire

// ==== verif/sd_card_model.sv ====
`default_nettype none

module sd_card_model (
	input wire logic sd_clock,
	input wire logic cmd_out,
	input wire logic cmd_oe,
	input wire logic silent,                   // no reply at all
	input wire sd_frame_pkg::cmd_frame_t reply,
	input wire logic [3:0] gap,                // cycles between command and reply
	output logic cmd_in,
	output sd_frame_pkg::cmd_frame_t cmd_seen,
	output int cmd_count
);
	timeunit 1ns;
	timeprecision 1ps;
	import sd_frame_pkg::*;

	cmd_frame_t frame;
	logic aborted;
	int i;

	initial begin
		cmd_in = 1'b1;
		cmd_seen = '0;
		cmd_count = 0;
		forever begin
			@(negedge sd_clock);
			if (cmd_oe && !cmd_out) begin // start bit from the host
				aborted = 1'b0;
				for (i = cmd_bits - 1; i >= 0 && !aborted; i--) begin
					if (!cmd_oe)
						aborted = 1'b1; // host dropped the line mid frame
					else
						frame[i] = cmd_out;
					if (i > 0 && !aborted)
						@(negedge sd_clock);
				end
				if (!aborted) begin
					cmd_seen <= frame;
					cmd_count <= cmd_count + 1;
					repeat (gap) @(posedge sd_clock);
					if (!silent) begin
						// reply goes out MSB first, start bit included
						for (i = cmd_bits - 1; i >= 0; i--) begin
							cmd_in <= reply[i];
							@(posedge sd_clock);
						end
						cmd_in <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/sd_cmd_phy_tb.sv ====
`default_nettype none

module sd_cmd_phy_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import sd_frame_pkg::*;

	localparam int resp_bits = 48;

	logic sd_clock;
	logic reset;
	logic strobe_in;
	logic ack_in;
	logic idle_in;
	logic no_response;
	cmd_frame_t command;
	logic serial_ready;
	logic strobe_out;
	logic ack_out;
	resp_frame_t response;
	logic command_timeout;
	logic cmd_out;
	logic cmd_oe;
	logic cmd_in;
	logic pad_enable;
	logic silent;
	cmd_frame_t card_reply;
	logic [3:0] gap;
	cmd_frame_t card_cmd;
	int card_count;
	int seed;
	int t;
	cmd_frame_t cmd_q[$];
	resp_frame_t resp_q[$];

	sd_cmd_phy #(
		.resp_bits(resp_bits),
		.timeout_limit(63)
	) u_dut (
		.sd_clock(sd_clock),
		.reset(reset),
		.strobe_in(strobe_in),
		.ack_in(ack_in),
		.idle_in(idle_in),
		.no_response(no_response),
		.command(command),
		.serial_ready(serial_ready),
		.strobe_out(strobe_out),
		.ack_out(ack_out),
		.response(response),
		.command_timeout(command_timeout),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.cmd_in(cmd_in),
		.pad_enable(pad_enable)
	);

	sd_card_model u_card (
		.sd_clock(sd_clock),
		.cmd_out(cmd_out),
		.cmd_oe(cmd_oe),
		.silent(silent),
		.reply(card_reply),
		.gap(gap),
		.cmd_in(cmd_in),
		.cmd_seen(card_cmd),
		.cmd_count(card_count)
	);

	initial begin
		sd_clock = 1'b0;
		forever #10 sd_clock = ~sd_clock;
	end

	task automatic fail_run();
		$display("Simulation FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_timeout(input string what);
		$display("timeout at %0t ns while waiting for %s", $time, what);
		fail_run();
	endtask

	task automatic check_cmd(input cmd_frame_t got, input cmd_frame_t exp, input string what);
		if (got !== exp) begin
			$display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_resp(input resp_frame_t got, input resp_frame_t exp, input string what);
		if (got !== exp) begin
			$display("error %0t ns: %s is %h, expected %h", $time, what, got, exp);
			fail_run();
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("error %0t ns: %s is %b, expected %b", $time, what, got, exp);
			fail_run();
		end
	endtask

	// card frame right-aligned in the container or all zero for a silent card
	function automatic resp_frame_t expect_response(input cmd_frame_t sent, input int nbits,
		input logic quiet);
		resp_frame_t r;
		r = '0;
		for (int i = 0; i < nbits && i < cmd_bits; i++)
			r[i] = quiet ? 1'b0 : sent[i];
		return r;
	endfunction

	// one-cycle strobe with a fresh random command and return at a falling edge
	task automatic issue_command(input logic quiet, input cmd_frame_t reply,
		output cmd_frame_t cmd);
		cmd = cmd_frame_t'({$random(seed), $random(seed)});
		cmd[47:46] = 2'b01;
		@(posedge sd_clock);
		command <= cmd;
		strobe_in <= 1'b1;
		silent <= quiet;
		card_reply <= reply;
		gap <= 4'(2 + {$random(seed)} % 9);
		@(posedge sd_clock);
		strobe_in <= 1'b0;
		@(negedge sd_clock);
	endtask

	task automatic run_transaction(input logic quiet);
		cmd_frame_t cmd;
		cmd_frame_t reply;
		int n;
		for (n = 0; !(serial_ready && !strobe_out && !cmd_oe); n++) begin
			if (n == 50)
				report_timeout("the DUT to return to idle");
			@(negedge sd_clock);
		end
		reply = cmd_frame_t'({$random(seed), $random(seed)});
		reply[47:46] = 2'b00; // start and transmission bits
		issue_command(quiet, reply, cmd);
		cmd_q.push_back(cmd);
		resp_q.push_back(expect_response(reply, resp_bits, quiet));
		if (quiet) begin
			for (n = 0; !command_timeout; n++) begin
				if (n == 200)
					report_timeout("command_timeout with a silent card");
				@(negedge sd_clock);
			end
			@(posedge sd_clock);
			no_response <= 1'b1;
			@(posedge sd_clock);
			no_response <= 1'b0;
			@(negedge sd_clock);
		end
		for (n = 0; !strobe_out; n++) begin
			if (n == 200)
				report_timeout("strobe_out");
			@(negedge sd_clock);
		end
		if (!quiet)
			check_bit(command_timeout, 1'b0, "command_timeout");
		repeat (1 + {$random(seed)} % 8) @(posedge sd_clock); // host holds off the ack
		ack_in <= 1'b1;
		@(posedge sd_clock);
		ack_in <= 1'b0;
		@(negedge sd_clock);
		for (n = 0; !ack_out; n++) begin
			if (n == 10)
				report_timeout("ack_out");
			@(negedge sd_clock);
		end
		@(negedge sd_clock);
		check_bit(ack_out, 1'b0, "ack_out one cycle later");
		check_bit(serial_ready, 1'b1, "serial_ready after ack");
		check_bit(strobe_out, 1'b0, "strobe_out after ack");
	endtask

	task automatic abort_transaction();
		cmd_frame_t cmd;
		int n;
		issue_command(1'b1, '0, cmd);
		for (n = 0; !cmd_oe; n++) begin
			if (n == 10)
				report_timeout("cmd_oe before the abort");
			@(negedge sd_clock);
		end
		repeat (5 + {$random(seed)} % 26) @(posedge sd_clock); // somewhere inside the frame
		idle_in <= 1'b1;
		@(posedge sd_clock);
		idle_in <= 1'b0;
		@(negedge sd_clock);
		check_bit(strobe_out, 1'b0, "strobe_out after idle_in");
		check_bit(serial_ready, 1'b1, "serial_ready after idle_in");
		check_bit(cmd_oe, 1'b0, "cmd_oe after idle_in");
	endtask

	// checks what the card captured and what the DUT returned against the queues
	initial begin : compare_results
		int seen;
		logic strobe_d;
		resp_frame_t held;
		seen = 0;
		strobe_d = 1'b0;
		held = '0;
		forever begin
			@(negedge sd_clock);
			if (card_count != seen) begin
				seen = card_count;
				if (cmd_q.size() == 0) begin
					$display("the card received a command that was never issued");
					fail_run();
				end
				check_cmd(card_cmd, cmd_q.pop_front(), "command seen by the card");
			end
			if (strobe_out && !strobe_d) begin
				if (resp_q.size() == 0) begin
					$display("strobe_out rose with no response expected");
					fail_run();
				end
				check_resp(response, resp_q.pop_front(), "response");
				held = response;
			end else if (strobe_out) begin
				check_resp(response, held, "response while waiting for ack");
			end
			strobe_d = strobe_out;
		end
	end

	initial begin
		int n;
		seed = 32'h608e;
		reset = 1'b1;
		strobe_in = 1'b0;
		ack_in = 1'b0;
		idle_in = 1'b0;
		no_response = 1'b0;
		command = '0;
		silent = 1'b0;
		card_reply = '0;
		gap = 4'd2;
		repeat (16) @(posedge sd_clock);
		reset <= 1'b0;
		@(negedge sd_clock);
		check_bit(strobe_out, 1'b0, "strobe_out after reset");
		check_bit(ack_out, 1'b0, "ack_out after reset");
		check_bit(command_timeout, 1'b0, "command_timeout after reset");
		check_bit(cmd_oe, 1'b0, "cmd_oe after reset");
		check_bit(pad_enable, 1'b0, "pad_enable after reset");
		check_bit(serial_ready, 1'b0, "serial_ready in the reset state");
		for (n = 0; !serial_ready; n++) begin
			if (n == 5)
				report_timeout("serial_ready after reset");
			@(negedge sd_clock);
		end
		for (t = 0; t < 4; t++)
			run_transaction(1'b0);
		run_transaction(1'b1);
		run_transaction(1'b0);
		abort_transaction();
		run_transaction(1'b0);
		repeat (4) @(negedge sd_clock);
		if (cmd_q.size() != 0 || resp_q.size() != 0) begin
			$display("%0d commands and %0d responses were never checked",
				cmd_q.size(), resp_q.size());
			fail_run();
		end else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== sd_cmd_phy.f ====
src/sd_frame_pkg.sv
src/sd_phy_ctrl_pkg.sv
src/cmd_serializer.sv
src/resp_deserializer.sv
src/cmd_phys_controller.sv
src/sd_cmd_phy.sv
verif/sd_card_model.sv
verif/sd_cmd_phy_tb.sv
